// File: Makefile
# Verilator build and run of the retire back end testbench
LOG = sim.log

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run backend_tb"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module backend_tb -Mdir obj_dir
	./obj_dir/Vbackend_tb | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean

// File: dv/backend_tb.sv
// ==============================
// Vector-driven testbench for backend_top
// Run from the project root so dv/retire_input.txt resolves
// File gives a live flag per line and the tag itself is modeled here
// ==============================
`timescale 1ns/100ps

module backend_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    logic                  in_ready;
    retire_pkg::op_t       in_op;
    retire_pkg::reg_addr_t in_rd;
    logic                  in_we;
    retire_pkg::word_t     in_result0;
    retire_pkg::word_t     in_result1;
    logic                  in_jump;
    retire_pkg::strobe_t   in_strobe;
    retire_pkg::word_t     in_mem_rdata;
    retire_pkg::word_t     in_pc;
    retire_pkg::tag_t      in_tag;
    logic                  in_illegal;
    retire_pkg::reg_addr_t rs1_addr;
    retire_pkg::reg_addr_t rs2_addr;
    retire_pkg::word_t     rs1_data;
    retire_pkg::word_t     rs2_data;
    logic                  redirect_valid;
    retire_pkg::word_t     redirect_pc;
    logic                  mem_valid;
    retire_pkg::word_t     mem_addr;
    retire_pkg::word_t     mem_wdata;
    retire_pkg::strobe_t   mem_strobe;
    logic                  mem_ready;

    string            vectors[$];      // Raw vector lines
    bit               loaded;          // Vector file has been read
    integer           seed;            // $random state
    int               checks;
    int               value_errors;
    int               other_errors;
    retire_pkg::tag_t exp_tag;         // Tag retire should currently accept

    backend_top UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Random memory back-pressure on about half the cycles
    always @(negedge clk) begin
        mem_ready <= ($random(seed) % 2) != 0;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    code;
        string line;
        fd = $fopen("dv/retire_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file dv/retire_input.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#")  // Skip comments and blank lines
                vectors.push_back(line);
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("The vector file holds no vectors");
            other_errors++;
        end
    endtask

    // Drive one instruction, wait for transfer and check the response
    task automatic apply_vector(input string line, input int idx);
        logic [31:0] op, rd, we, r0, r1, jump, strobe, rdata, pc, live, ill;
        logic [31:0] e_rd, e_val, e_redir, e_rpc, e_st, e_addr, e_data, e_strobe;
        int          n;
        int          step;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    op, rd, we, r0, r1, jump, strobe, rdata, pc, live, ill,
                    e_rd, e_val, e_redir, e_rpc, e_st, e_addr, e_data, e_strobe);
        if (n != 19) begin
            $display("Vector %0d has %0d fields instead of 19, skipped", idx, n);
            other_errors++;
            return;
        end
        @(negedge clk);
        in_op        = op[5:0];
        in_rd        = rd[4:0];
        in_we        = we[0];
        in_result0   = r0;
        in_result1   = r1;
        in_jump      = jump[0];
        in_strobe    = strobe[3:0];
        in_mem_rdata = rdata;
        in_pc        = pc;
        in_tag       = live[0] ? exp_tag : exp_tag - 4'd1;  // Stale tag gets killed
        in_illegal   = ill[0];
        in_valid     = 1'b1;
        #2;
        while (!in_ready) begin        // Stalled by a held store
            @(negedge clk);
            #2;
        end
        @(posedge clk);                // Transfer edge
        if (live[0] && e_redir[0])
            exp_tag = exp_tag + 4'd1;  // Every retire redirect bumps the tag
        step = 0;
        while (step < 3 || mem_valid) begin
            @(negedge clk);
            if (step == 0) begin
                in_valid = 1'b0;
                rs1_addr = e_rd[4:0];
                rs2_addr = e_rd[4:0];
            end
            #2;
            step++;
            if (step == 1) begin
                check_value("rs1_data", rs1_data, e_val);
                check_value("rs2_data", rs2_data, e_val);
                check_value("mem_valid", {31'd0, mem_valid}, e_st);
            end
            if (mem_valid && e_st[0]) begin    // Store must hold until taken
                check_value("mem_addr", mem_addr, e_addr);
                check_value("mem_wdata", mem_wdata, e_data);
                check_value("mem_strobe", {28'd0, mem_strobe}, e_strobe);
                check_value("in_ready", {31'd0, in_ready}, {31'd0, mem_ready});
            end
            if (step <= 3)             // Redirect only in the second cycle after
                check_value("redirect_valid", {31'd0, redirect_valid},
                            (step == 2) ? e_redir : 32'd0);
            if (step == 2 && e_redir[0])
                check_value("redirect_pc", redirect_pc, e_rpc);
        end
    endtask

    initial begin
        seed         = 75;
        clk          = 1'b0;
        reset        = 1'b0;           // Held in reset from time zero
        in_valid     = 1'b0;
        in_op        = '0;
        in_rd        = '0;
        in_we        = 1'b0;
        in_result0   = '0;
        in_result1   = '0;
        in_jump      = 1'b0;
        in_strobe    = '0;
        in_mem_rdata = '0;
        in_pc        = '0;
        in_tag       = '0;
        in_illegal   = 1'b0;
        rs1_addr     = '0;
        rs2_addr     = '0;
        mem_ready    = 1'b1;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        exp_tag      = '0;
        load_vectors();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset    = 1'b1;
        rs1_addr = 5'd31;
        #2;
        check_value("mem_valid", {31'd0, mem_valid}, 32'd0);
        check_value("redirect_valid", {31'd0, redirect_valid}, 32'd0);
        check_value("in_ready", {31'd0, in_ready}, 32'd1);
        check_value("rs1_data", rs1_data, 32'd0);
        foreach (vectors[i]) begin
            apply_vector(vectors[i], i);
        end
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Watchdog allows 50 cycles per vector after reset
    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + 50 * (vectors.size() + 1)) @(posedge clk);
        $display("Timeout: the vectors did not finish in the allowed time");
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors + 1);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: dv/retire_input.txt
# op rd we result0 result1 jump strobe mem_rdata pc live illegal (live 0 = stale tag)
# expected: rd value, redirect flag pc, store flag addr data strobe (all hex)
08 01 1 12345678 00000000 0 0 00000000 00001000 1 0 01 12345678 0 00000000 0 00000000 00000000 0
20 02 1 00000000 00002000 0 0 000000f0 00001004 1 0 02 fffffff0 0 00000000 0 00000000 00000000 0
21 03 1 00000000 00002001 0 0 123456f0 00001008 1 0 03 000000f0 0 00000000 0 00000000 00000000 0
22 04 1 00000000 00002002 0 0 00008001 0000100c 1 0 04 ffff8001 0 00000000 0 00000000 00000000 0
23 05 1 00000000 00002004 0 0 abcd8001 00001010 1 0 05 00008001 0 00000000 0 00000000 00000000 0
24 06 1 00000000 00002008 0 0 cafef00d 00001014 1 0 06 cafef00d 0 00000000 0 00000000 00000000 0
08 00 1 deadbeef 00000000 0 0 00000000 00001018 1 0 00 00000000 0 00000000 0 00000000 00000000 0
10 00 0 00000000 00002000 1 0 00000000 0000101c 1 0 01 12345678 1 00002000 0 00000000 00000000 0
08 07 1 11111111 00000000 0 0 00000000 00001020 0 0 07 00000000 0 00000000 0 00000000 00000000 0
25 00 0 55555555 00003100 0 f 00000000 00001024 0 0 07 00000000 0 00000000 0 00000000 00000000 0
25 00 0 a5a5a5a5 00003000 0 f 00000000 00002000 1 0 01 12345678 0 00000000 1 00003000 a5a5a5a5 f
25 00 0 000000ee 00003004 0 1 00000000 00002004 1 0 02 fffffff0 0 00000000 1 00003004 000000ee 1
08 08 1 99999999 00000000 0 0 00000000 00002008 1 1 08 00000000 1 00000100 0 00000000 00000000 0
3a 00 0 00000000 00000000 0 0 00000000 00000100 1 0 00 00000000 1 0000200c 0 00000000 00000000 0
38 00 0 00000000 00000000 0 0 00000000 00002010 1 0 00 00000000 1 00000100 0 00000000 00000000 0
3a 00 0 00000000 00000000 0 0 00000000 00000100 1 0 00 00000000 1 00002014 0 00000000 00000000 0
39 00 0 00000000 00000000 0 0 00000000 00002020 1 0 00 00000000 1 00000100 0 00000000 00000000 0
3a 00 0 00000000 00000000 0 0 00000000 00000104 1 0 00 00000000 1 00002024 0 00000000 00000000 0
10 09 1 0000202c 00003000 1 0 00000000 00002028 1 0 09 0000202c 1 00003000 0 00000000 00000000 0
10 00 0 00000000 00004400 0 0 00000000 00003000 1 0 09 0000202c 0 00000000 0 00000000 00000000 0
10 00 0 00000000 00004000 1 0 00000000 00003004 1 0 09 0000202c 1 00004000 0 00000000 00000000 0
38 00 0 00000000 00000000 0 0 00000000 00004000 1 0 00 00000000 1 00000100 0 00000000 00000000 0
3a 00 0 00000000 00000000 0 0 00000000 00000100 1 0 00 00000000 1 00004004 0 00000000 00000000 0
10 00 0 00000000 00005000 1 0 00000000 00004004 1 0 00 00000000 1 00005000 0 00000000 00000000 0
08 0b 1 77777777 00000000 0 0 00000000 00005000 1 1 0b 00000000 1 00000100 0 00000000 00000000 0
3a 00 0 00000000 00000000 0 0 00000000 00000100 1 0 00 00000000 1 00005004 0 00000000 00000000 0
10 00 0 00000000 00006000 1 0 00000000 00005004 1 0 00 00000000 1 00006000 0 00000000 00000000 0
39 00 0 00000000 00000000 0 0 00000000 00006000 1 0 00 00000000 1 00000100 0 00000000 00000000 0
08 0c 1 0badf00d 00000000 0 0 00000000 00006004 1 0 0c 0badf00d 0 00000000 0 00000000 00000000 0
08 0d 1 13131313 00000000 0 0 00000000 00006008 0 0 0d 00000000 0 00000000 0 00000000 00000000 0
3a 00 0 00000000 00000000 0 0 00000000 00000100 1 0 00 00000000 1 00006004 0 00000000 00000000 0

// File: filelist.f
rtl/retire_pkg.sv
rtl/exec_retire_if.sv
rtl/retire.sv
rtl/reg_bank.sv
rtl/trap_unit.sv
rtl/backend_top.sv
dv/backend_tb.sv

// File: rtl/backend_top.sv
// ==============================
// Back end top, retire with register bank and trap unit
// Redirect 2 cycles after transfer, store 1 cycle after
// in_ready depends on mem_ready combinationally
// ==============================
`timescale 1ns/100ps

module backend_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  retire_pkg::op_t       in_op,
    input  retire_pkg::reg_addr_t in_rd,
    input  logic                  in_we,
    input  retire_pkg::word_t     in_result0,
    input  retire_pkg::word_t     in_result1,
    input  logic                  in_jump,
    input  retire_pkg::strobe_t   in_strobe,
    input  retire_pkg::word_t     in_mem_rdata,
    input  retire_pkg::word_t     in_pc,
    input  retire_pkg::tag_t      in_tag,
    input  logic                  in_illegal,
    input  retire_pkg::reg_addr_t rs1_addr,
    input  retire_pkg::reg_addr_t rs2_addr,
    output retire_pkg::word_t     rs1_data,
    output retire_pkg::word_t     rs2_data,
    output logic                  redirect_valid,
    output retire_pkg::word_t     redirect_pc,
    output logic                  mem_valid,
    output retire_pkg::word_t     mem_addr,
    output retire_pkg::word_t     mem_wdata,
    output retire_pkg::strobe_t   mem_strobe,
    input  logic                  mem_ready
);

    exec_retire_if er_if ();           // Execute side driven from ports

    logic                  rf_we;
    retire_pkg::reg_addr_t rf_addr;
    retire_pkg::word_t     rf_wdata;
    logic                  branch_valid;
    retire_pkg::word_t     branch_target;
    logic                  trap_valid;
    retire_pkg::cause_t    trap_cause;
    retire_pkg::word_t     trap_pc;
    logic                  mret_valid;

    assign er_if.valid     = in_valid;
    assign er_if.op        = in_op;
    assign er_if.rd        = in_rd;
    assign er_if.we        = in_we;
    assign er_if.result0   = in_result0;
    assign er_if.result1   = in_result1;
    assign er_if.jump      = in_jump;
    assign er_if.strobe    = in_strobe;
    assign er_if.mem_rdata = in_mem_rdata;
    assign er_if.pc        = in_pc;
    assign er_if.tag       = in_tag;
    assign er_if.illegal   = in_illegal;
    assign in_ready        = er_if.ready;

    retire u_retire (
        .clk, .reset, .in(er_if.retire), .mem_ready,
        .rf_we, .rf_addr, .rf_wdata,
        .branch_valid, .branch_target,
        .trap_valid, .trap_cause, .trap_pc, .mret_valid,
        .mem_valid, .mem_addr, .mem_wdata, .mem_strobe
    );

    reg_bank u_reg_bank (
        .clk, .reset, .we(rf_we), .waddr(rf_addr), .wdata(rf_wdata),
        .raddr_a(rs1_addr), .raddr_b(rs2_addr),
        .rdata_a(rs1_data), .rdata_b(rs2_data)
    );

    trap_unit u_trap_unit (
        .clk, .reset, .branch_valid, .branch_target,
        .trap_valid, .trap_cause, .trap_pc, .mret_valid,
        .redirect_valid, .redirect_pc
    );

endmodule

// File: rtl/exec_retire_if.sv
// ==============================
// Execute to retire instruction stream
// Valid/ready, fields held while stalled
// ==============================
`timescale 1ns/100ps

interface exec_retire_if;

    logic                  valid;      // Instruction present
    logic                  ready;      // Retire can take it
    retire_pkg::op_t       op;         // Operation class
    retire_pkg::reg_addr_t rd;         // Destination register
    logic                  we;         // Register write-enable
    retire_pkg::word_t     result0;    // Writeback value or store data
    retire_pkg::word_t     result1;    // Branch target or store address
    logic                  jump;       // Branch taken
    retire_pkg::strobe_t   strobe;     // Store byte mask
    retire_pkg::word_t     mem_rdata;  // Raw load data
    retire_pkg::word_t     pc;         // Instruction PC
    retire_pkg::tag_t      tag;        // Execution tag
    logic                  illegal;    // Flagged by decode

    modport execute (
        output valid, op, rd, we, result0, result1, jump,
        output strobe, mem_rdata, pc, tag, illegal,
        input  ready
    );

    modport retire (
        input  valid, op, rd, we, result0, result1, jump,
        input  strobe, mem_rdata, pc, tag, illegal,
        output ready
    );

endinterface

// File: rtl/reg_bank.sv
// ==============================
// RV32 register file, x0 reads zero
// One write port, two combinational reads
// Write and read of the same index give the old value
// ==============================
`timescale 1ns/100ps

module reg_bank (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  retire_pkg::reg_addr_t waddr,
    input  retire_pkg::word_t     wdata,
    input  retire_pkg::reg_addr_t raddr_a,
    input  retire_pkg::reg_addr_t raddr_b,
    output retire_pkg::word_t     rdata_a,
    output retire_pkg::word_t     rdata_b
);

    retire_pkg::word_t regs [retire_pkg::REG_COUNT];  // Architectural state

    // Registers all start at zero
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < retire_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin  // x0 is hardwired
            regs[waddr] <= wdata;
        end
    end

    // Operand reads for the wider core
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

// File: rtl/retire.sv
// ==============================
// Last pipeline stage that commits or kills each instruction
// Memory back-pressure stalls every instruction and not just stores
// Load data must arrive already shifted to bit 0
// ==============================
`timescale 1ns/100ps

module retire (
    input  logic                  clk,
    input  logic                  reset,
    exec_retire_if.retire         in,
    input  logic                  mem_ready,
    output logic                  rf_we,
    output retire_pkg::reg_addr_t rf_addr,
    output retire_pkg::word_t     rf_wdata,
    output logic                  branch_valid,
    output retire_pkg::word_t     branch_target,
    output logic                  trap_valid,
    output retire_pkg::cause_t    trap_cause,
    output retire_pkg::word_t     trap_pc,
    output logic                  mret_valid,
    output logic                  mem_valid,
    output retire_pkg::word_t     mem_addr,
    output retire_pkg::word_t     mem_wdata,
    output retire_pkg::strobe_t   mem_strobe
);

    retire_pkg::tag_t   cur_tag;       // Tag of the current correct path
    retire_pkg::word_t  wb_data;       // Extended writeback value
    retire_pkg::cause_t cause_next;    // Cause for a trap this cycle

    logic transfer;                    // Handshake completes
    logic live;                        // Transferred with a matching tag
    logic commit;                      // Live and allowed to touch state
    logic store_go;                    // Load the store holding register
    logic req_illegal;
    logic req_ecall;
    logic req_ebreak;
    logic req_trap;                    // Any of the three above
    logic req_mret;
    logic req_branch;
    logic req_any;                     // Retire redirects fetch

    // Held store blocks the stream until memory takes it
    assign in.ready = !(mem_valid && !mem_ready);

    assign transfer = in.valid && in.ready;
    assign live     = transfer && (in.tag == cur_tag);   // Wrong-path kill
    assign commit   = live && !in.illegal;               // Illegal writes nothing

    // Writeback value by op class
    always_comb begin
        case (in.op)
            retire_pkg::OP_LB:  wb_data = {{24{in.mem_rdata[7]}}, in.mem_rdata[7:0]};
            retire_pkg::OP_LBU: wb_data = {24'h00_0000, in.mem_rdata[7:0]};
            retire_pkg::OP_LH:  wb_data = {{16{in.mem_rdata[15]}}, in.mem_rdata[15:0]};
            retire_pkg::OP_LHU: wb_data = {16'h0000, in.mem_rdata[15:0]};
            retire_pkg::OP_LW:  wb_data = in.mem_rdata;
            default:            wb_data = in.result0;  // ALU result or link address
        endcase
    end

    // Register write lands on the transfer edge
    assign rf_we    = commit && in.we;
    assign rf_addr  = in.rd;
    assign rf_wdata = wb_data;

    assign store_go = commit && (in.strobe != '0);

    // Redirect sources in priority order
    assign req_illegal = live && in.illegal;
    assign req_ecall   = live && !in.illegal && (in.op == retire_pkg::OP_ECALL);
    assign req_ebreak  = live && !in.illegal && (in.op == retire_pkg::OP_EBREAK);
    assign req_trap    = req_illegal || req_ecall || req_ebreak;
    assign req_mret    = commit && (in.op == retire_pkg::OP_MRET);
    assign req_branch  = commit && (in.op == retire_pkg::OP_BRANCH) && in.jump;
    assign req_any     = req_trap || req_mret || req_branch;

    always_comb begin
        if (in.illegal)
            cause_next = retire_pkg::CAUSE_ILLEGAL;
        else if (in.op == retire_pkg::OP_ECALL)
            cause_next = retire_pkg::CAUSE_ECALL_M;
        else
            cause_next = retire_pkg::CAUSE_BREAKPOINT;
    end

    // Control state
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cur_tag      <= '0;
            branch_valid <= 1'b0;
            trap_valid   <= 1'b0;
            mret_valid   <= 1'b0;
            mem_valid    <= 1'b0;
        end else begin
            branch_valid <= req_branch;    // One-cycle pulses
            trap_valid   <= req_trap;
            mret_valid   <= req_mret;
            if (req_any)
                cur_tag <= cur_tag + 1'b1; // Younger instructions now die
            if (store_go)
                mem_valid <= 1'b1;         // New store may follow a drain
            else if (mem_ready)
                mem_valid <= 1'b0;
        end
    end

    // Request and store payloads
    always_ff @(posedge clk) begin
        if (req_branch)
            branch_target <= in.result1;
        if (req_trap) begin
            trap_cause <= cause_next;
            trap_pc    <= in.pc;
        end
        if (store_go) begin
            mem_addr   <= in.result1;
            mem_wdata  <= in.result0;
            mem_strobe <= in.strobe;
        end
    end

endmodule

// File: rtl/retire_pkg.sv
// ==============================
// Shared types and constants for the retire back end
// Widths fixed by RV32I, machine mode only
// Trap vector is a constant, there is no writable mtvec
// ==============================
package retire_pkg;

    typedef logic [31:0] word_t;       // Data word, address or PC
    typedef logic [3:0]  tag_t;        // Execution tag, wraps
    typedef logic [4:0]  reg_addr_t;   // Register index
    typedef logic [5:0]  op_t;         // Upper 3 bits pick the unit
    typedef logic [3:0]  strobe_t;     // Store byte mask, 0 = no store
    typedef logic [3:0]  cause_t;      // mcause code

    localparam int REG_COUNT = 32;     // Architectural registers

    // Execution unit codes, top three bits of op_t
    localparam logic [2:0] XU_ALU    = 3'b001;
    localparam logic [2:0] XU_MEMORY = 3'b100;

    localparam op_t OP_ALU    = {XU_ALU, 3'b000};     // Any ALU result
    localparam op_t OP_BRANCH = 6'b010_000;           // Branch and jump
    localparam op_t OP_LB     = {XU_MEMORY, 3'b000};  // Signed byte
    localparam op_t OP_LBU    = {XU_MEMORY, 3'b001};  // Unsigned byte
    localparam op_t OP_LH     = {XU_MEMORY, 3'b010};  // Signed half
    localparam op_t OP_LHU    = {XU_MEMORY, 3'b011};  // Unsigned half
    localparam op_t OP_LW     = {XU_MEMORY, 3'b100};  // Full word
    localparam op_t OP_STORE  = {XU_MEMORY, 3'b101};  // Any store width
    localparam op_t OP_ECALL  = 6'b111_000;           // System unit
    localparam op_t OP_EBREAK = 6'b111_001;
    localparam op_t OP_MRET   = 6'b111_010;

    // Standard machine-mode exception codes
    localparam cause_t CAUSE_ILLEGAL    = 4'd2;
    localparam cause_t CAUSE_BREAKPOINT = 4'd3;
    localparam cause_t CAUSE_ECALL_M    = 4'd11;

    localparam word_t TRAP_VECTOR = 32'h0000_0100;    // Fixed handler entry

endpackage

// File: rtl/trap_unit.sv
// ==============================
// Machine-mode trap state and fetch redirect
// Requests are one-hot, at most one per cycle
// mepc holds the trapping PC, MRET resumes at mepc + 4
// ==============================
`timescale 1ns/100ps

module trap_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               branch_valid,
    input  retire_pkg::word_t  branch_target,
    input  logic               trap_valid,
    input  retire_pkg::cause_t trap_cause,
    input  retire_pkg::word_t  trap_pc,
    input  logic               mret_valid,
    output logic               redirect_valid,
    output retire_pkg::word_t  redirect_pc
);

    retire_pkg::word_t  mepc;          // PC of the last trap
    retire_pkg::cause_t mcause;        // Cause of the last trap
    retire_pkg::word_t  next_pc;       // Selected redirect target

    // Trap first, then return, then branch
    always_comb begin
        if (trap_valid)
            next_pc = retire_pkg::TRAP_VECTOR;
        else if (mret_valid)
            next_pc = mepc + 32'd4;    // Skip the trapping instruction
        else
            next_pc = branch_target;
    end

    // CSR state
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mepc   <= '0;
            mcause <= '0;
        end else if (trap_valid) begin
            mepc   <= trap_pc;
            mcause <= trap_cause;
        end
    end

    // Redirect pulse, one cycle behind the request
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            redirect_valid <= 1'b0;
        else
            redirect_valid <= branch_valid || trap_valid || mret_valid;
    end

    always_ff @(posedge clk) begin
        redirect_pc <= next_pc;        // Only meaningful with redirect_valid
    end

endmodule
